// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int INST_W     = 32;
    localparam int OPCODE_W   = 7;
    localparam int F3_W       = 3;
    localparam int F7_W       = 7;
    localparam int SHAMT_W    = 5;

    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int F7_LSB     = 25;
    localparam int IMM_I_LSB  = 20;     // I-type immediate is inst[31:20]
    localparam int IMM_U_LSB  = 12;     // U-type immediate is inst[31:12]

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes and function codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    localparam logic [F3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [F3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [F3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [F3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [F3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [F3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [F3_W-1:0] F3_OR      = 3'b110;
    localparam logic [F3_W-1:0] F3_AND     = 3'b111;

    localparam logic [F7_W-1:0] F7_BASE    = 7'b0000000;
    localparam logic [F7_W-1:0] F7_ALT     = 7'b0100000;   // selects SUB and SRA

endpackage

// ==== rtl/id_pkg.sv ====
package id_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation handed to execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_AND  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_op_e;

    // the result class picks which execute unit drives the write-back value
    typedef enum logic [1:0] {
        SEL_NOP   = 2'd0,
        SEL_ARITH = 2'd1,
        SEL_LOGIC = 2'd2,
        SEL_SHIFT = 2'd3
    } alu_sel_e;

endpackage

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file #(
    parameter int DATA_W    = 32,
    parameter int REG_COUNT = 32
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [$clog2(REG_COUNT)-1:0] rs1_addr_i,
    input  logic [$clog2(REG_COUNT)-1:0] rs2_addr_i,
    output logic [DATA_W-1:0]            rs1_data_o,
    output logic [DATA_W-1:0]            rs2_data_o,
    input  logic                         wb_we_i,
    input  logic [$clog2(REG_COUNT)-1:0] wb_addr_i,
    input  logic [DATA_W-1:0]            wb_data_i
);

    localparam int ADDR_W = $clog2(REG_COUNT);

    logic [DATA_W-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i && (wb_addr_i != '0)) begin     // x0 stays zero
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // reads see the value before this cycle's write
    assign rs1_data_o = (rs1_addr_i == ADDR_W'(0)) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == ADDR_W'(0)) ? '0 : regs[rs2_addr_i];

endmodule

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder import rv_isa_pkg::*, id_pkg::*; (
    input  logic                  rst_n_i,
    input  logic [INST_W-1:0]     inst_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output alu_op_e               alu_op_o,
    output alu_sel_e              alu_sel_o,
    output logic                  wreg_o,
    output logic                  rs1_read_o,
    output logic                  rs2_read_o,
    output logic [XLEN-1:0]       imm_o,
    output logic                  imm_valid_o
);

    logic [OPCODE_W-1:0] opcode;
    logic [F3_W-1:0]     funct3;
    logic [F7_W-1:0]     funct7;
    logic                f7_base;
    logic                f7_alt;
    logic                f7_ok_reg;
    logic                f7_ok_imm;
    alu_op_e             f3_op;
    alu_sel_e            f3_sel;
    logic [XLEN-1:0]     imm_i_type;
    logic [XLEN-1:0]     imm_shamt;
    logic [XLEN-1:0]     imm_u_type;

    assign opcode     = inst_i[OPCODE_LSB +: OPCODE_W];
    assign funct3     = inst_i[F3_LSB +: F3_W];
    assign funct7     = inst_i[F7_LSB +: F7_W];
    assign rs1_addr_o = inst_i[RS1_LSB +: REG_ADDR_W];
    assign rs2_addr_o = inst_i[RS2_LSB +: REG_ADDR_W];
    assign rd_addr_o  = inst_i[RD_LSB +: REG_ADDR_W];

    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    // only ADD/SUB and SRL/SRA accept the alternate funct7
    assign f7_ok_reg = f7_base || (f7_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
    assign f7_ok_imm = (funct3 == F3_SLL)     ? f7_base :
                       (funct3 == F3_SRL_SRA) ? (f7_base || f7_alt) : 1'b1;

    assign imm_i_type = {{(XLEN-12){inst_i[INST_W-1]}}, inst_i[INST_W-1:IMM_I_LSB]};
    assign imm_shamt  = {{(XLEN-SHAMT_W){1'b0}}, inst_i[IMM_I_LSB +: SHAMT_W]};
    assign imm_u_type = {inst_i[INST_W-1:IMM_U_LSB], {IMM_U_LSB{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct3 table, shared by register and immediate forms
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (funct3)
            F3_ADD_SUB: f3_op = f7_alt ? ALU_SUB : ALU_ADD;
            F3_SLT:     f3_op = ALU_SLT;
            F3_SLTU:    f3_op = ALU_SLTU;
            F3_XOR:     f3_op = ALU_XOR;
            F3_OR:      f3_op = ALU_OR;
            F3_AND:     f3_op = ALU_AND;
            F3_SLL:     f3_op = ALU_SLL;
            default:    f3_op = f7_alt ? ALU_SRA : ALU_SRL;
        endcase
        case (funct3)
            F3_ADD_SUB, F3_SLT, F3_SLTU: f3_sel = SEL_ARITH;
            F3_XOR, F3_OR, F3_AND:       f3_sel = SEL_LOGIC;
            default:                     f3_sel = SEL_SHIFT;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_NOP;
        alu_sel_o   = SEL_NOP;
        wreg_o      = 1'b0;
        rs1_read_o  = 1'b0;
        rs2_read_o  = 1'b0;
        imm_o       = '0;
        imm_valid_o = 1'b0;
        if (rst_n_i) begin
            case (opcode)
                OPC_OP: begin
                    if (f7_ok_reg) begin
                        alu_op_o   = f3_op;
                        alu_sel_o  = f3_sel;
                        wreg_o     = 1'b1;
                        rs1_read_o = 1'b1;
                        rs2_read_o = 1'b1;
                    end
                end
                OPC_OP_IMM: begin
                    if (f7_ok_imm) begin
                        alu_op_o    = (funct3 == F3_ADD_SUB) ? ALU_ADD : f3_op;  // no SUBI
                        alu_sel_o   = f3_sel;
                        wreg_o      = 1'b1;
                        rs1_read_o  = 1'b1;
                        imm_o       = (f3_sel == SEL_SHIFT) ? imm_shamt : imm_i_type;
                        imm_valid_o = 1'b1;
                    end
                end
                OPC_LUI: begin
                    alu_op_o    = ALU_OR;       // zero op1 OR immediate gives the immediate
                    alu_sel_o   = SEL_LOGIC;
                    wreg_o      = 1'b1;
                    imm_o       = imm_u_type;
                    imm_valid_o = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== rtl/operand_fwd.sv ====
`timescale 1ns/100ps

module operand_fwd import id_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  rs1_read_i,
    input  logic                  rs2_read_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic                  imm_valid_i,
    input  logic [XLEN-1:0]       rf_rs1_data_i,
    input  logic [XLEN-1:0]       rf_rs2_data_i,
    input  logic                  ex_wreg_i,
    input  logic                  ex_load_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [XLEN-1:0]       ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [XLEN-1:0]       mem_wdata_i,
    output logic [XLEN-1:0]       op1_o,
    output logic [XLEN-1:0]       op2_o,
    output logic                  stall_o
);

    logic op1_stall;
    logic op2_stall;

    // returns {stall, value} for one operand
    function automatic logic [XLEN:0] pick_operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic                  rd,
        input logic [XLEN-1:0]       rf_data,
        input logic [XLEN-1:0]       alt_data,
        input logic                  alt_en
    );
        logic nz;
        nz = (addr != '0);
        if (!rd) begin
            return {1'b0, (alt_en ? alt_data : {XLEN{1'b0}})};
        end
        // a pending load cannot forward yet and stalls even an x0 read
        if (ex_load_i && (ex_wd_i == addr)) begin
            return {1'b1, {XLEN{1'b0}}};
        end
        if (ex_wreg_i && (ex_wd_i == addr) && nz) begin
            return {1'b0, ex_wdata_i};
        end
        if (mem_wreg_i && (mem_wd_i == addr) && nz) begin
            return {1'b0, mem_wdata_i};
        end
        if (nz) begin
            return {1'b0, rf_data};
        end
        return '0;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        {op1_stall, op1_o} = pick_operand(rs1_addr_i, rs1_read_i, rf_rs1_data_i, '0, 1'b0);
        {op2_stall, op2_o} = pick_operand(rs2_addr_i, rs2_read_i, rf_rs2_data_i,
                                          imm_i, imm_valid_i);
    end

    assign stall_o = op1_stall | op2_stall;

endmodule

// ==== rtl/id_stage.sv ====
`timescale 1ns/100ps

module id_stage import rv_isa_pkg::*, id_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [INST_W-1:0]     inst_i,
    input  logic                  ex_wreg_i,
    input  logic                  ex_load_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [XLEN-1:0]       ex_wdata_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [XLEN-1:0]       mem_wdata_i,
    input  logic                  wb_we_i,
    input  logic [REG_ADDR_W-1:0] wb_addr_i,
    input  logic [XLEN-1:0]       wb_data_i,
    output alu_op_e               alu_op_o,
    output alu_sel_e              alu_sel_o,
    output logic                  wreg_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       op1_o,
    output logic [XLEN-1:0]       op2_o,
    output logic                  stall_o
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic                  rs1_read;
    logic                  rs2_read;
    logic [XLEN-1:0]       imm;
    logic                  imm_valid;
    logic [XLEN-1:0]       rf_rs1_data;
    logic [XLEN-1:0]       rf_rs2_data;

    inst_decoder decoder_i (
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rd_addr_o   (rd_addr_o),
        .alu_op_o    (alu_op_o),
        .alu_sel_o   (alu_sel_o),
        .wreg_o      (wreg_o),
        .rs1_read_o  (rs1_read),
        .rs2_read_o  (rs2_read),
        .imm_o       (imm),
        .imm_valid_o (imm_valid)
    );

    operand_fwd fwd_i (
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .rs1_read_i    (rs1_read),
        .rs2_read_i    (rs2_read),
        .imm_i         (imm),
        .imm_valid_i   (imm_valid),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .ex_wreg_i     (ex_wreg_i),
        .ex_load_i     (ex_load_i),
        .ex_wd_i       (ex_wd_i),
        .ex_wdata_i    (ex_wdata_i),
        .mem_wreg_i    (mem_wreg_i),
        .mem_wd_i      (mem_wd_i),
        .mem_wdata_i   (mem_wdata_i),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .stall_o       (stall_o)
    );

    reg_file #(
        .DATA_W    (XLEN),
        .REG_COUNT (REG_COUNT)
    ) rf_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .wb_we_i    (wb_we_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

endmodule

// ==== tests/id_stage_tb.sv ====
`timescale 1ns/100ps

module id_stage_tb
    import rv_isa_pkg::*, id_pkg::*;
();

    logic                  clk;
    logic                  rst_n_i;
    logic [INST_W-1:0]     inst_i;
    logic                  ex_wreg_i;
    logic                  ex_load_i;
    logic [REG_ADDR_W-1:0] ex_wd_i;
    logic [XLEN-1:0]       ex_wdata_i;
    logic                  mem_wreg_i;
    logic [REG_ADDR_W-1:0] mem_wd_i;
    logic [XLEN-1:0]       mem_wdata_i;
    logic                  wb_we_i;
    logic [REG_ADDR_W-1:0] wb_addr_i;
    logic [XLEN-1:0]       wb_data_i;
    alu_op_e               alu_op_o;
    alu_sel_e              alu_sel_o;
    logic                  wreg_o;
    logic [REG_ADDR_W-1:0] rd_addr_o;
    logic [XLEN-1:0]       op1_o;
    logic [XLEN-1:0]       op2_o;
    logic                  stall_o;

    alu_op_e               exp_op;
    alu_sel_e              exp_sel;
    logic                  exp_wreg;
    logic [REG_ADDR_W-1:0] exp_rd;
    logic [XLEN-1:0]       exp_op1;
    logic [XLEN-1:0]       exp_op2;
    logic                  exp_stall;
    int                    cycle_count = 0;
    int                    cycle_limit = 10;     // replaced once the case count is known

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run("the run did not finish within the cycle limit");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_alu_op(input string name, input alu_op_e expected, input alu_op_e actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %s, got %s (%0d)", $time, name,
                     expected.name(), actual.name(), actual);
            fail_run("decoded ALU operation is wrong");
        end
    endtask

    task automatic check_alu_sel(input string name, input alu_sel_e expected,
                                 input alu_sel_e actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %s, got %s (%0d)", $time, name,
                     expected.name(), actual.name(), actual);
            fail_run("decoded result class is wrong");
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            fail_run("an output word is wrong");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %b, got %b", $time, name, expected, actual);
            fail_run("an output flag is wrong");
        end
    endtask

    task automatic check_outputs();
        check_alu_op("alu_op_o", exp_op, alu_op_o);
        check_alu_sel("alu_sel_o", exp_sel, alu_sel_o);
        check_bit("wreg_o", exp_wreg, wreg_o);
        check_word("rd_addr_o", XLEN'(exp_rd), XLEN'(rd_addr_o));
        check_word("op1_o", exp_op1, op1_o);
        check_word("op2_o", exp_op2, op2_o);
        check_bit("stall_o", exp_stall, stall_o);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // case file reading
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_tag(input int fd, output string tag, output bit got);
        int  c;
        bit  done;
        got  = 1'b0;
        done = 1'b0;
        while (!done) begin
            if ($fscanf(fd, " %s", tag) != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin     // drop the rest of a comment line
                    c = $fgetc(fd);
                end
            end else begin
                got  = 1'b1;
                done = 1'b1;
            end
        end
    endtask

    task automatic find_op(input string name, output alu_op_e op);
        alu_op_e v;
        v = v.first();
        repeat (v.num()) begin
            if (v.name() == name) begin
                op = v;
                return;
            end
            v = v.next();
        end
        fail_run({"unknown ALU operation in case file: ", name});
    endtask

    task automatic find_sel(input string name, output alu_sel_e sel);
        alu_sel_e v;
        v = v.first();
        repeat (v.num()) begin
            if (v.name() == name) begin
                sel = v;
                return;
            end
            v = v.next();
        end
        fail_run({"unknown result class in case file: ", name});
    endtask

    task automatic apply_write(input int fd);
        int              addr;
        logic [XLEN-1:0] data;
        if ($fscanf(fd, " %d %h", addr, data) != 2) begin
            fail_run("a W line in the case file is malformed");
        end
        @(posedge clk);
        wb_we_i   <= 1'b1;
        wb_addr_i <= REG_ADDR_W'(addr);
        wb_data_i <= data;
        @(negedge clk);
        check_outputs();    // the write lands at the next edge, so reads still see the old value
    endtask

    task automatic apply_decode(input int fd);
        logic [INST_W-1:0] inst;
        int                ex_wreg;
        int                ex_load;
        int                ex_wd;
        logic [XLEN-1:0]   ex_wdata;
        int                mem_wreg;
        int                mem_wd;
        logic [XLEN-1:0]   mem_wdata;
        string             op_name;
        string             sel_name;
        int                wreg;
        int                rd;
        int                stall;
        if ($fscanf(fd, " %h %d %d %d %h %d %d %h", inst, ex_wreg, ex_load, ex_wd, ex_wdata,
                    mem_wreg, mem_wd, mem_wdata) != 8) begin
            fail_run("the inputs of a D line in the case file are malformed");
        end
        if ($fscanf(fd, " %s %s %d %d %h %h %d", op_name, sel_name, wreg, rd, exp_op1, exp_op2,
                    stall) != 7) begin
            fail_run("the expected results of a D line in the case file are malformed");
        end
        find_op(op_name, exp_op);
        find_sel(sel_name, exp_sel);
        exp_wreg  = (wreg != 0);
        exp_rd    = REG_ADDR_W'(rd);
        exp_stall = (stall != 0);
        @(posedge clk);
        inst_i      <= inst;
        ex_wreg_i   <= (ex_wreg != 0);
        ex_load_i   <= (ex_load != 0);
        ex_wd_i     <= REG_ADDR_W'(ex_wd);
        ex_wdata_i  <= ex_wdata;
        mem_wreg_i  <= (mem_wreg != 0);
        mem_wd_i    <= REG_ADDR_W'(mem_wd);
        mem_wdata_i <= mem_wdata;
        wb_we_i     <= 1'b0;
        @(negedge clk);
        check_outputs();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int    fd;
        int    case_count;
        int    done_count;
        string tag;
        bit    got;
        // ADD x4, x1, x2 with a pending load to x1 would stall if it were decoded
        rst_n_i     <= 1'b0;
        inst_i      <= 32'h0020_8233;
        ex_wreg_i   <= 1'b1;
        ex_load_i   <= 1'b1;
        ex_wd_i     <= 5'd1;
        ex_wdata_i  <= 32'h5555_0001;
        mem_wreg_i  <= 1'b1;
        mem_wd_i    <= 5'd2;
        mem_wdata_i <= 32'h6666_0002;
        wb_we_i     <= 1'b0;
        wb_addr_i   <= '0;
        wb_data_i   <= '0;
        done_count  = 0;
        fd = $fopen("tests/id_stage_cases.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open tests/id_stage_cases.txt");
        end
        next_tag(fd, tag, got);
        if (!got || tag != "N" || $fscanf(fd, " %d", case_count) != 1) begin
            fail_run("the case file does not start with its case count");
        end
        cycle_limit = 2 * case_count + 10;

        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_alu_op("alu_op_o", ALU_NOP, alu_op_o);
            check_alu_sel("alu_sel_o", SEL_NOP, alu_sel_o);
            check_bit("wreg_o", 1'b0, wreg_o);
            check_bit("stall_o", 1'b0, stall_o);
            check_word("op1_o", '0, op1_o);
            check_word("op2_o", '0, op2_o);
        end
        @(posedge clk);
        rst_n_i    <= 1'b1;
        inst_i     <= '0;
        ex_wreg_i  <= 1'b0;
        ex_load_i  <= 1'b0;
        mem_wreg_i <= 1'b0;

        next_tag(fd, tag, got);
        while (got) begin
            if (tag == "W") begin
                apply_write(fd);
            end else if (tag == "D") begin
                apply_decode(fd);
            end else begin
                fail_run({"unknown line type in case file: ", tag});
            end
            done_count++;
            next_tag(fd, tag, got);
        end
        $fclose(fd);
        @(posedge clk);
        wb_we_i <= 1'b0;
        if (done_count != case_count) begin
            fail_run("the case file holds a different number of cases than its count says");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/id_stage_cases.txt ====
# W addr(dec) data(hex) : one register write through the write-back port
# D inst ex_wreg ex_load ex_wd ex_wdata mem_wreg mem_wd mem_wdata op sel wreg rd op1 op2 stall
N 25
D 00628233 0 0  0 00000000 0 0 00000000 ALU_ADD  SEL_ARITH 1  4 00000000 00000000 0
W  0 deadbeef
W  1 00000011
W  2 fffffff0
W  3 12345678
D 402083b3 0 0  0 00000000 0 0 00000000 ALU_SUB  SEL_ARITH 1  7 00000011 fffffff0 0
D 00304433 0 0  0 00000000 0 0 00000000 ALU_XOR  SEL_LOGIC 1  8 00000000 12345678 0
D 401154b3 0 0  0 00000000 0 0 00000000 ALU_SRA  SEL_SHIFT 1  9 fffffff0 00000011 0
D 0021b533 0 0  0 00000000 0 0 00000000 ALU_SLTU SEL_ARITH 1 10 12345678 fffffff0 0
D ffb08593 0 0  0 00000000 0 0 00000000 ALU_ADD  SEL_ARITH 1 11 00000011 fffffffb 0
D 40415613 0 0  0 00000000 0 0 00000000 ALU_SRA  SEL_SHIFT 1 12 fffffff0 00000004 0
D 01f19693 0 0  0 00000000 0 0 00000000 ALU_SLL  SEL_SHIFT 1 13 12345678 0000001f 0
D abcde737 0 0  0 00000000 0 0 00000000 ALU_OR   SEL_LOGIC 1 14 00000000 abcde000 0
D 0000a283 0 0  0 00000000 0 0 00000000 ALU_NOP  SEL_NOP   0  5 00000000 00000000 0
D 02208033 0 0  0 00000000 0 0 00000000 ALU_NOP  SEL_NOP   0  0 00000000 00000000 0
D 402083b3 1 0  1 aaaa0001 1 1 bbbb0001 ALU_SUB  SEL_ARITH 1  7 aaaa0001 fffffff0 0
D 402083b3 1 0  3 aaaa0003 1 2 bbbb0002 ALU_SUB  SEL_ARITH 1  7 00000011 bbbb0002 0
D 00304433 1 0  0 cccc0000 1 0 cccc0001 ALU_XOR  SEL_LOGIC 1  8 00000000 12345678 0
D 402083b3 1 1  2 dddd0002 0 0 00000000 ALU_SUB  SEL_ARITH 1  7 00000011 00000000 1
D abcde737 1 1 27 dddd001b 0 0 00000000 ALU_OR   SEL_LOGIC 1 14 00000000 abcde000 0
D ffb08593 1 1 27 dddd001b 0 0 00000000 ALU_ADD  SEL_ARITH 1 11 00000011 fffffffb 0
D 00304433 1 1  0 dddd0000 0 0 00000000 ALU_XOR  SEL_LOGIC 1  8 00000000 12345678 1
D 00628233 0 0  0 00000000 0 0 00000000 ALU_ADD  SEL_ARITH 1  4 00000000 00000000 0
W  5 00000055
D 00628233 0 0  0 00000000 0 0 00000000 ALU_ADD  SEL_ARITH 1  4 00000055 00000000 0

// ==== src.f ====
rtl/rv_isa_pkg.sv
rtl/id_pkg.sv
rtl/reg_file.sv
rtl/inst_decoder.sv
rtl/operand_fwd.sv
rtl/id_stage.sv
tests/id_stage_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the id_stage testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module id_stage_tb -f src.f -o sim_id_stage \
    && ./obj_dir/sim_id_stage \
    || { echo "simulation build or run did not succeed"; exit 1; }
